//--- src/video_core_config.svh
//////////////////////////////////////////////////
// video core geometry and audio constants
// raster sizes, sync placement, pattern blue
// level and i2s clock division
//////////////////////////////////////////////////

`ifndef VIDEO_CORE_CONFIG_SVH
`define VIDEO_CORE_CONFIG_SVH

// horizontal raster, in core clocks
`define VID_H_TOTAL    400
`define VID_H_ACTIVE   320
// first visible column
`define VID_H_BPORCH   10

// vertical raster, in lines
`define VID_V_TOTAL    512
`define VID_V_ACTIVE   240
// first visible line
`define VID_V_BPORCH   10

// hs sits a few clocks after line start, clear of vs
`define VID_HS_OFFSET  3

// constant blue channel of the gradient
`define PATTERN_BLUE   64

// 12.288 mhz / 4 gives a 3.072 mhz bit clock
`define I2S_SCLK_DIV          4
// 32 bits per channel, 64 per frame, so 48 khz
`define I2S_BITS_PER_CHANNEL  32

`endif

//--- src/video_core_pkg.sv
//////////////////////////////////////////////////
// video core shared types
// raster widths, pixel layout and the bundled
// video and i2s output groups
//////////////////////////////////////////////////

package video_core_pkg;

    // raster position, wide enough for 400 columns and 512 lines
    typedef logic [9:0] hcount_t;
    typedef logic [9:0] vcount_t;

    // one colour channel
    typedef logic [7:0] color_t;

    // packed pixel word, red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] rgb_t;

    // pattern pixel, field order matches rgb_t
    typedef struct packed {
        color_t red;
        color_t green;
        color_t blue;
    } pixel_t;

    // video bundle to the scaler
    typedef struct packed {
        rgb_t rgb;
        logic de;
        logic vs;
        logic hs;
    } video_out_t;

    // i2s bundle to the codec
    typedef struct packed {
        logic sclk;
        logic lrck;
        logic dac;
    } i2s_out_t;

endpackage

//--- src/raster_timing.sv
//////////////////////////////////////////////////
// raster timing generator
// 400x512 counters, one-clock vs and hs pulses,
// data enable window and registered video outputs
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "video_core_config.svh"

module raster_timing (
    input  logic                       clk_core_12288,
    input  logic                       reset_n,
    input  video_core_pkg::pixel_t     pixel,
    output logic                       frame_start,
    output logic                       pixel_step,
    output video_core_pkg::video_out_t video
);

    import video_core_pkg::*;

    // last counter values before wrap
    localparam hcount_t H_LAST  = hcount_t'(`VID_H_TOTAL - 1);
    localparam vcount_t V_LAST  = vcount_t'(`VID_V_TOTAL - 1);

    // visible window, start inclusive and end exclusive
    localparam hcount_t H_START = hcount_t'(`VID_H_BPORCH);
    localparam hcount_t H_END   = hcount_t'(`VID_H_BPORCH + `VID_H_ACTIVE);
    localparam vcount_t V_START = vcount_t'(`VID_V_BPORCH);
    localparam vcount_t V_END   = vcount_t'(`VID_V_BPORCH + `VID_V_ACTIVE);

    // hs column within each line
    localparam hcount_t HS_COL  = hcount_t'(`VID_HS_OFFSET);

    hcount_t h_count;
    vcount_t v_count;

    logic    h_active;
    logic    v_active;
    logic    active;
    logic    frame_origin;
    logic    line_hs;

    //////////////////////////////////////////////////
    // position counters
    //////////////////////////////////////////////////

    // column runs every clock, line advances on column wrap
    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            h_count <= '0;
            v_count <= '0;
        end else begin
            if (h_count == H_LAST) begin
                h_count <= '0;
                if (v_count == V_LAST) begin
                    v_count <= '0;
                end else begin
                    v_count <= v_count + vcount_t'(1);
                end
            end else begin
                h_count <= h_count + hcount_t'(1);
            end
        end
    end

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    // active window, the only place it is decoded
    assign h_active     = (h_count >= H_START) && (h_count < H_END);
    assign v_active     = (v_count >= V_START) && (v_count < V_END);
    assign active       = h_active && v_active;

    // top left corner of the frame
    assign frame_origin = (h_count == '0) && (v_count == '0);
    // hs comes a little after line start on every line
    assign line_hs      = (h_count == HS_COL);

    // strobes to the pattern block, same cycle as the position
    assign frame_start  = frame_origin;
    assign pixel_step   = active;

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////

    // one clock behind the counters
    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            video <= '0;
        end else begin
            video.vs <= frame_origin;
            video.hs <= line_hs;
            video.de <= active;
            // black outside the visible window
            if (active) begin
                video.rgb <= rgb_t'(pixel);
            end else begin
                video.rgb <= '0;
            end
        end
    end

endmodule

//--- src/test_pattern.sv
//////////////////////////////////////////////////
// gradient test pattern
// red follows the column, green follows the row,
// blue held at a fixed level
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "video_core_config.svh"

module test_pattern (
    input  logic                   clk_core_12288,
    input  logic                   reset_n,
    input  logic                   frame_start,
    input  logic                   pixel_step,
    output video_core_pkg::pixel_t pixel
);

    import video_core_pkg::*;

    // last visible column index
    localparam logic [8:0] COL_LAST = 9'(`VID_H_ACTIVE - 1);

    // fixed blue channel
    localparam color_t BLUE_LEVEL   = color_t'(`PATTERN_BLUE);

    // column 0..319, needs 9 bits
    logic [8:0] col_count;
    // row 0..239, fits a colour channel
    color_t     row_count;

    //////////////////////////////////////////////////
    // pattern counters
    //////////////////////////////////////////////////

    // counters hold the position of the pixel now on the raster
    // and move on the clock after each strobe
    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            col_count <= '0;
            row_count <= '0;
        end else if (frame_start) begin
            // back to the top left pixel
            col_count <= '0;
            row_count <= '0;
        end else if (pixel_step) begin
            if (col_count == COL_LAST) begin
                // end of visible line, next row
                col_count <= '0;
                row_count <= row_count + color_t'(1);
            end else begin
                col_count <= col_count + 9'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // colour
    //////////////////////////////////////////////////

    // red wraps every 256 columns
    assign pixel.red   = col_count[7:0];
    assign pixel.green = row_count;
    assign pixel.blue  = BLUE_LEVEL;

endmodule

//--- src/i2s_silence.sv
//////////////////////////////////////////////////
// i2s silence generator
// bit clock and word select for 48 khz stereo,
// data line held low
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "video_core_config.svh"

module i2s_silence (
    input  logic                     clk_core_12288,
    input  logic                     reset_n,
    output video_core_pkg::i2s_out_t audio
);

    import video_core_pkg::*;

    localparam int DIV_W  = $clog2(`I2S_SCLK_DIV);
    localparam int BIT_W  = $clog2(`I2S_BITS_PER_CHANNEL);

    // divider phases where sclk rises and falls next clock
    localparam logic [DIV_W-1:0] DIV_RISE = DIV_W'(`I2S_SCLK_DIV / 2 - 1);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`I2S_SCLK_DIV - 1);
    // last bit of a channel
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`I2S_BITS_PER_CHANNEL - 1);

    logic [DIV_W-1:0] div_count;
    logic [BIT_W-1:0] bit_count;
    logic             sclk_fall;

    // sclk drops on the next clock
    assign sclk_fall = (div_count == DIV_LAST);

    //////////////////////////////////////////////////
    // bit clock and word select
    //////////////////////////////////////////////////

    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            div_count <= '0;
            bit_count <= '0;
            audio     <= '0;
        end else begin
            // core clock divider, low half then high half
            if (sclk_fall) begin
                div_count  <= '0;
                audio.sclk <= 1'b0;
            end else begin
                div_count <= div_count + DIV_W'(1);
                if (div_count == DIV_RISE) begin
                    audio.sclk <= 1'b1;
                end
            end
            // count bits on each falling edge
            // channel swap lands on the same falling edge
            if (sclk_fall) begin
                bit_count <= bit_count + BIT_W'(1);
                if (bit_count == BIT_LAST) begin
                    audio.lrck <= ~audio.lrck;
                end
            end
            // silence only
            audio.dac <= 1'b0;
        end
    end

endmodule

//--- src/video_core_top.sv
//////////////////////////////////////////////////
// video core top level
// raster timing, test pattern and silent i2s audio
// in the 12.288 mhz pixel clock domain
//////////////////////////////////////////////////

`timescale 1ns/1ps

module video_core_top (
    input  logic                       clk_core_12288,
    input  logic                       reset_n,
    output video_core_pkg::video_out_t video,
    output video_core_pkg::i2s_out_t   audio
);

    import video_core_pkg::*;

    // strobes from timing to pattern
    logic   frame_start;
    logic   pixel_step;
    // pixel at the current raster position
    pixel_t pixel;

    //////////////////////////////////////////////////
    // video path
    //////////////////////////////////////////////////

    // counters, sync, de and the output register
    raster_timing u_raster_timing (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .pixel          (pixel),
        .frame_start    (frame_start),
        .pixel_step     (pixel_step),
        .video          (video)
    );

    // gradient source, follows the timing strobes
    test_pattern u_test_pattern (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .frame_start    (frame_start),
        .pixel_step     (pixel_step),
        .pixel          (pixel)
    );

    //////////////////////////////////////////////////
    // audio path
    //////////////////////////////////////////////////

    // free running, no link to the raster
    i2s_silence u_i2s_silence (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .audio          (audio)
    );

endmodule

//--- test/tb_video_core.sv
//////////////////////////////////////////////////
// video core testbench
// raster timing, gradient pixels and i2s silence
// checked against the timing rules of the core
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_video_core;

    import video_core_pkg::*;

    // one table row with raster position and expected colour
    typedef struct packed {
        logic [15:0] row;
        logic [15:0] col;
        pixel_t      expected;
    } sample_t;

    localparam int N_FIXED    = 8;
    localparam int N_RAND     = 4;
    localparam int N_SAMPLES  = N_FIXED + N_RAND;
    localparam int N_TESTS    = 5;
    localparam int WAIT_LIMIT = 300000;

    logic       clk_core_12288;
    logic       reset_n;
    video_out_t video;
    i2s_out_t   audio;

    sample_t     samples [0:N_SAMPLES-1];
    int          test_errors [0:N_TESTS-1];
    int unsigned lcg_state;
    bit          timed_out;

    // monitor state in cycles since reset release
    int   cycle;
    int   vs_count;
    int   last_vs;
    int   last_hs;
    bit   hs_seen;
    bit   first_hs_pending;
    int   de_lines;
    int   run_start;
    logic prev_de;
    logic prev_sclk;
    logic prev_lrck;
    int   last_sclk_edge;
    int   last_lrck_edge;
    // pixel seen on the latest de cycle
    int   px_row;
    int   px_col;
    rgb_t px_rgb;
    bit   px_valid;

    video_core_top u_video_core_top (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .video          (video),
        .audio          (audio)
    );

    // 100 ns period
    always #50 clk_core_12288 = ~clk_core_12288;

    //////////////////////////////////////////////////
    // raster and audio monitor
    //////////////////////////////////////////////////

    always @(posedge clk_core_12288) begin
        if (reset_n) begin
            // first clock after release still shows reset values
            if (cycle == 0) begin
                assert (video == '0 && audio == '0) else begin
                    $display("ERR %0t: outputs not idle on first clock", $time);
                    test_errors[0]++;
                end
            end
            // frame sync spacing and line count per frame
            if (video.vs) begin
                if (vs_count > 0) begin
                    assert (cycle - last_vs == 204800) else begin
                        $display("ERR %0t: vs spacing %0d", $time, cycle - last_vs);
                        test_errors[1]++;
                    end
                    assert (de_lines == 240) else begin
                        $display("ERR %0t: %0d de lines in frame", $time, de_lines);
                        test_errors[2]++;
                    end
                end
                vs_count++;
                last_vs          = cycle;
                de_lines         = 0;
                first_hs_pending = 1'b1;
            end
            // line sync spacing and the first hs 3 after vs
            if (video.hs) begin
                if (hs_seen) begin
                    assert (cycle - last_hs == 400) else begin
                        $display("ERR %0t: hs spacing %0d", $time, cycle - last_hs);
                        test_errors[1]++;
                    end
                end
                if (first_hs_pending) begin
                    assert (cycle - last_vs == 3) else begin
                        $display("ERR %0t: hs after vs by %0d", $time, cycle - last_vs);
                        test_errors[1]++;
                    end
                    first_hs_pending = 1'b0;
                end
                hs_seen = 1'b1;
                last_hs = cycle;
            end
            // de runs and pixel position tracking
            if (video.de) begin
                if (!prev_de) begin
                    assert (cycle - last_hs == 7) else begin
                        $display("ERR %0t: de after hs by %0d", $time, cycle - last_hs);
                        test_errors[2]++;
                    end
                    if (de_lines == 0 && vs_count > 0) begin
                        assert (cycle - last_vs == 4010) else begin
                            $display("ERR %0t: first de after vs by %0d", $time,
                                     cycle - last_vs);
                            test_errors[2]++;
                        end
                    end
                    run_start = cycle;
                    px_row    = de_lines;
                    px_col    = 0;
                    de_lines++;
                end else begin
                    px_col++;
                end
                px_rgb   = video.rgb;
                px_valid = 1'b1;
            end else begin
                px_valid = 1'b0;
                // blanking must be black
                assert (video.rgb == '0) else begin
                    $display("ERR %0t: rgb %06h while de low", $time, video.rgb);
                    test_errors[3]++;
                end
                if (prev_de) begin
                    assert (cycle - run_start == 320) else begin
                        $display("ERR %0t: de run of %0d", $time, cycle - run_start);
                        test_errors[2]++;
                    end
                end
            end
            // i2s edges
            if (audio.sclk != prev_sclk) begin
                assert (cycle - last_sclk_edge == 2) else begin
                    $display("ERR %0t: sclk edge spacing %0d", $time, cycle - last_sclk_edge);
                    test_errors[4]++;
                end
                last_sclk_edge = cycle;
            end
            if (audio.lrck != prev_lrck) begin
                assert (cycle - last_lrck_edge == 128 && prev_sclk && !audio.sclk) else begin
                    $display("ERR %0t: lrck edge spacing %0d or off sclk fall", $time,
                             cycle - last_lrck_edge);
                    test_errors[4]++;
                end
                last_lrck_edge = cycle;
            end
            assert (audio.dac == 1'b0) else begin
                $display("ERR %0t: dac not zero", $time);
                test_errors[4]++;
            end
            prev_de   = video.de;
            prev_sclk = audio.sclk;
            prev_lrck = audio.lrck;
            cycle++;
        end
    end

    //////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic sample_t make_sample(input int row, input int col);
        sample_t s;
        s.row            = 16'(row);
        s.col            = 16'(col);
        // gradient rule
        s.expected.red   = color_t'(col % 256);
        s.expected.green = color_t'(row);
        s.expected.blue  = color_t'(64);
        return s;
    endfunction

    task automatic load_samples();
        int r;
        int c;
        // corners, byte wrap of red and a mid point
        samples[0] = {16'd0,   16'd0,   8'd0,   8'd0,   8'd64};
        samples[1] = {16'd0,   16'd1,   8'd1,   8'd0,   8'd64};
        samples[2] = {16'd0,   16'd255, 8'd255, 8'd0,   8'd64};
        samples[3] = {16'd0,   16'd256, 8'd0,   8'd0,   8'd64};
        samples[4] = {16'd0,   16'd319, 8'd63,  8'd0,   8'd64};
        samples[5] = {16'd1,   16'd0,   8'd0,   8'd1,   8'd64};
        samples[6] = {16'd120, 16'd160, 8'd160, 8'd120, 8'd64};
        samples[7] = {16'd239, 16'd319, 8'd63,  8'd239, 8'd64};
        for (int i = N_FIXED; i < N_SAMPLES; i++) begin
            lcg_state  = lcg_next(lcg_state);
            r          = int'((lcg_state >> 8) % 240);
            lcg_state  = lcg_next(lcg_state);
            c          = int'((lcg_state >> 8) % 320);
            samples[i] = make_sample(r, c);
        end
    endtask

    // raster order so one frame covers the whole table
    task automatic sort_samples();
        sample_t tmp;
        for (int i = 0; i < N_SAMPLES - 1; i++) begin
            for (int j = 0; j < N_SAMPLES - 1 - i; j++) begin
                if (samples[j].row * 320 + samples[j].col >
                    samples[j+1].row * 320 + samples[j+1].col) begin
                    tmp          = samples[j];
                    samples[j]   = samples[j+1];
                    samples[j+1] = tmp;
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // bounded waits
    //////////////////////////////////////////////////

    task automatic wait_for_cycle(input int target, input int test_idx);
        int waited;
        waited = 0;
        while (!timed_out && cycle < target) begin
            @(negedge clk_core_12288);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: clock count never reached %0d", target);
                timed_out = 1'b1;
                test_errors[test_idx]++;
            end
        end
    endtask

    task automatic wait_for_pixel(input int row, input int col);
        int waited;
        waited = 0;
        while (!timed_out && !(px_valid && px_row == row && px_col == col)) begin
            @(negedge clk_core_12288);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: pixel at row %0d column %0d never shown", row, col);
                timed_out = 1'b1;
                test_errors[3]++;
            end
        end
    endtask

    task automatic wait_for_vs_count(input int target);
        int waited;
        waited = 0;
        while (!timed_out && vs_count < target) begin
            @(negedge clk_core_12288);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: vertical sync number %0d never came", target);
                timed_out = 1'b1;
                test_errors[1]++;
            end
        end
    endtask

    task automatic check_pixel(input sample_t s);
        assert (px_rgb == rgb_t'(s.expected)) else begin
            $display("ERR %0t: pixel row %0d col %0d got %06h expected %06h", $time,
                     s.row, s.col, px_rgb, rgb_t'(s.expected));
            test_errors[3]++;
        end
    endtask

    // sclk and lrck edges must keep coming
    task automatic check_i2s_running();
        assert (cycle - last_sclk_edge <= 2) else begin
            $display("ERR %0t: sclk stopped toggling, last edge at cycle %0d", $time,
                     last_sclk_edge);
            test_errors[4]++;
        end
        assert (cycle - last_lrck_edge <= 128) else begin
            $display("ERR %0t: lrck stopped toggling, last edge at cycle %0d", $time,
                     last_lrck_edge);
            test_errors[4]++;
        end
    endtask

    task automatic report_test(input int idx, input string name);
        if (test_errors[idx] == 0) begin
            $display("test %0d %s: ok", idx + 1, name);
        end else begin
            $display("test %0d %s: %0d errors", idx + 1, name, test_errors[idx]);
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        int total;
        int failed;
        clk_core_12288   = 1'b0;
        reset_n          = 1'b0;
        timed_out        = 1'b0;
        lcg_state        = 32'd18;
        cycle            = 0;
        vs_count         = 0;
        last_vs          = 0;
        last_hs          = 0;
        hs_seen          = 1'b0;
        first_hs_pending = 1'b0;
        de_lines         = 0;
        run_start        = 0;
        prev_de          = 1'b0;
        prev_sclk        = 1'b0;
        prev_lrck        = 1'b0;
        last_sclk_edge   = 0;
        last_lrck_edge   = 0;
        px_row           = 0;
        px_col           = 0;
        px_rgb           = '0;
        px_valid         = 1'b0;
        for (int i = 0; i < N_TESTS; i++) begin
            test_errors[i] = 0;
        end
        load_samples();
        sort_samples();

        // reset for 8 cycles with outputs idle throughout
        repeat (8) begin
            @(negedge clk_core_12288);
            assert (video == '0 && audio == '0) else begin
                $display("ERR %0t: outputs not idle during reset", $time);
                test_errors[0]++;
            end
        end
        reset_n = 1'b1;
        wait_for_cycle(1, 0);
        report_test(0, "reset values");

        // table pixels in the first frame
        for (int i = 0; i < N_SAMPLES; i++) begin
            wait_for_pixel(samples[i].row, samples[i].col);
            if (!timed_out) begin
                check_pixel(samples[i]);
            end
        end
        report_test(3, "pattern pixels");

        // two full frames for the sync and de checks
        wait_for_vs_count(2);
        wait_for_vs_count(3);
        check_i2s_running();
        report_test(1, "sync spacing");
        report_test(2, "data enable");
        report_test(4, "i2s silence");

        total  = 0;
        failed = 0;
        for (int i = 0; i < N_TESTS; i++) begin
            total += test_errors[i];
            if (test_errors[i] != 0) begin
                failed++;
            end
        end
        $display("summary: %0d tests, %0d ok, %0d with errors, %0d errors in all",
                 N_TESTS, N_TESTS - failed, failed, total);
        if (total == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- video_core_top.f
+incdir+src
src/video_core_pkg.sv
src/raster_timing.sv
src/test_pattern.sv
src/i2s_silence.sv
src/video_core_top.sv
test/tb_video_core.sv

//--- Bender.yml
package:
  name: video_core

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/video_core_pkg.sv
      - src/raster_timing.sv
      - src/test_pattern.sv
      - src/i2s_silence.sv
      - src/video_core_top.sv
  - target: test
    files:
      - test/tb_video_core.sv
